/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_axi_aw_xbar
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
+incdir+src
src/axi_pkg.sv
src/xbar_pkg.sv
src/aw_if.sv
src/b_if.sv
src/aw_router.sv
src/b_router.sv
src/default_slave.sv
src/axi_aw_xbar.sv
test/tb_axi_aw_xbar.sv

/* src/aw_if.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

interface aw_if #(
  parameter int ID_BITS = `AXI_ID_BITS
);
  import axi_pkg::*;

  logic [ID_BITS-1:0]        id;
  logic [`AXI_ADDR_BITS-1:0] addr;
  logic [`AXI_LEN_BITS-1:0]  len;
  logic [`AXI_SIZE_BITS-1:0] size;
  burst_t                    burst;
  logic                      valid;
  logic                      ready;

  modport sender (output id, addr, len, size, burst, valid, input ready);
  modport receiver (input id, addr, len, size, burst, valid, output ready);

endinterface

/* src/aw_router.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

module aw_router (
  input logic    clk,
  input logic    rstn,
  aw_if.receiver m,
  aw_if.sender   s0,
  aw_if.sender   s1,
  aw_if.sender   s2,
  input logic    b_done
);
  import axi_pkg::*;
  import xbar_pkg::*;

  addr_arb_lock_t           lock_q;
  addr_arb_lock_t           lock_d;
  addr_view_u               addr_view;
  addr_dec_result_t         target;
  logic [`AXI_IDS_BITS-1:0] tagged_id;
  logic [2:0]               sel;
  logic                     grant;
  logic                     outstanding;
  logic                     fwd_valid;
  logic                     slave_ready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_FREE;
    end else begin
      lock_q <= lock_d;
    end
  end

  // A handshake in the request cycle leaves the lock free
  always_comb begin
    lock_d = lock_q;
    unique case (lock_q)
      LOCK_FREE: if (m.valid && !m.ready) lock_d = LOCK_M1;
      LOCK_M1:   if (m.valid && m.ready) lock_d = LOCK_FREE;
    endcase
  end

  // One write in flight until its response reaches the master
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      outstanding <= 1'b0;
    end else if (m.valid && m.ready) begin
      outstanding <= 1'b1;
    end else if (b_done) begin
      outstanding <= 1'b0;
    end
  end

  assign grant = (lock_q == LOCK_M1) || m.valid;
  assign fwd_valid = m.valid & ~outstanding;
  assign tagged_id = {AXI_MASTER_1_ID, m.id};

  assign addr_view.raw = m.addr;
  assign target = addr_decoder(addr_view);

  always_comb begin
    sel = 3'b000;
    if (grant) begin
      unique case (target)
        SLAVE_0:       sel = 3'b001;
        SLAVE_1:       sel = 3'b010;
        SLAVE_DEFAULT: sel = 3'b100;
        default:       sel = 3'b000;
      endcase
    end
  end

  assign slave_ready = |(sel & {s2.ready, s1.ready, s0.ready});
  assign m.ready = slave_ready & ~outstanding;

  assign s0.valid = sel[0] & fwd_valid;
  assign s0.id    = sel[0] ? tagged_id : '0;
  assign s0.addr  = sel[0] ? addr_view.raw : '0;
  assign s0.len   = sel[0] ? m.len : '0;
  assign s0.size  = sel[0] ? m.size : '0;
  assign s0.burst = sel[0] ? m.burst : BURST_FIXED;

  assign s1.valid = sel[1] & fwd_valid;
  assign s1.id    = sel[1] ? tagged_id : '0;
  assign s1.addr  = sel[1] ? addr_view.raw : '0;
  assign s1.len   = sel[1] ? m.len : '0;
  assign s1.size  = sel[1] ? m.size : '0;
  assign s1.burst = sel[1] ? m.burst : BURST_FIXED;

  // Default slave
  assign s2.valid = sel[2] & fwd_valid;
  assign s2.id    = sel[2] ? tagged_id : '0;
  assign s2.addr  = sel[2] ? addr_view.raw : '0;
  assign s2.len   = sel[2] ? m.len : '0;
  assign s2.size  = sel[2] ? m.size : '0;
  assign s2.burst = sel[2] ? m.burst : BURST_FIXED;

endmodule

/* src/axi_aw_xbar.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

module axi_aw_xbar (
  input  logic                      clk,
  input  logic                      rstn,
  // Master
  input  logic [`AXI_ID_BITS-1:0]   awid,
  input  logic [`AXI_ADDR_BITS-1:0] awaddr,
  input  logic [`AXI_LEN_BITS-1:0]  awlen,
  input  logic [`AXI_SIZE_BITS-1:0] awsize,
  input  axi_pkg::burst_t           awburst,
  input  logic                      awvalid,
  output logic                      awready,
  output logic [`AXI_ID_BITS-1:0]   bid,
  output axi_pkg::resp_t            bresp,
  output logic                      bvalid,
  input  logic                      bready,
  // Slave 0
  output logic [`AXI_IDS_BITS-1:0]  s0_awid,
  output logic [`AXI_ADDR_BITS-1:0] s0_awaddr,
  output logic [`AXI_LEN_BITS-1:0]  s0_awlen,
  output logic [`AXI_SIZE_BITS-1:0] s0_awsize,
  output axi_pkg::burst_t           s0_awburst,
  output logic                      s0_awvalid,
  input  logic                      s0_awready,
  input  logic [`AXI_IDS_BITS-1:0]  s0_bid,
  input  axi_pkg::resp_t            s0_bresp,
  input  logic                      s0_bvalid,
  output logic                      s0_bready,
  // Slave 1
  output logic [`AXI_IDS_BITS-1:0]  s1_awid,
  output logic [`AXI_ADDR_BITS-1:0] s1_awaddr,
  output logic [`AXI_LEN_BITS-1:0]  s1_awlen,
  output logic [`AXI_SIZE_BITS-1:0] s1_awsize,
  output axi_pkg::burst_t           s1_awburst,
  output logic                      s1_awvalid,
  input  logic                      s1_awready,
  input  logic [`AXI_IDS_BITS-1:0]  s1_bid,
  input  axi_pkg::resp_t            s1_bresp,
  input  logic                      s1_bvalid,
  output logic                      s1_bready
);

  logic b_done;

  aw_if #(.ID_BITS(`AXI_ID_BITS))  m_aw ();
  aw_if #(.ID_BITS(`AXI_IDS_BITS)) s0_aw ();
  aw_if #(.ID_BITS(`AXI_IDS_BITS)) s1_aw ();
  aw_if #(.ID_BITS(`AXI_IDS_BITS)) s2_aw ();

  b_if #(.ID_BITS(`AXI_ID_BITS))  m_b ();
  b_if #(.ID_BITS(`AXI_IDS_BITS)) s0_b ();
  b_if #(.ID_BITS(`AXI_IDS_BITS)) s1_b ();
  b_if #(.ID_BITS(`AXI_IDS_BITS)) s2_b ();

  assign m_aw.id    = awid;
  assign m_aw.addr  = awaddr;
  assign m_aw.len   = awlen;
  assign m_aw.size  = awsize;
  assign m_aw.burst = awburst;
  assign m_aw.valid = awvalid;
  assign awready    = m_aw.ready;

  assign bid        = m_b.id;
  assign bresp      = m_b.resp;
  assign bvalid     = m_b.valid;
  assign m_b.ready  = bready;

  assign s0_awid    = s0_aw.id;
  assign s0_awaddr  = s0_aw.addr;
  assign s0_awlen   = s0_aw.len;
  assign s0_awsize  = s0_aw.size;
  assign s0_awburst = s0_aw.burst;
  assign s0_awvalid = s0_aw.valid;
  assign s0_aw.ready = s0_awready;

  assign s0_b.id    = s0_bid;
  assign s0_b.resp  = s0_bresp;
  assign s0_b.valid = s0_bvalid;
  assign s0_bready  = s0_b.ready;

  assign s1_awid    = s1_aw.id;
  assign s1_awaddr  = s1_aw.addr;
  assign s1_awlen   = s1_aw.len;
  assign s1_awsize  = s1_aw.size;
  assign s1_awburst = s1_aw.burst;
  assign s1_awvalid = s1_aw.valid;
  assign s1_aw.ready = s1_awready;

  assign s1_b.id    = s1_bid;
  assign s1_b.resp  = s1_bresp;
  assign s1_b.valid = s1_bvalid;
  assign s1_bready  = s1_b.ready;

  aw_router u_aw_router (
    .clk    (clk),
    .rstn   (rstn),
    .m      (m_aw),
    .s0     (s0_aw),
    .s1     (s1_aw),
    .s2     (s2_aw),
    .b_done (b_done)
  );

  b_router u_b_router (
    .clk    (clk),
    .rstn   (rstn),
    .s0     (s0_b),
    .s1     (s1_b),
    .s2     (s2_b),
    .m      (m_b),
    .b_done (b_done)
  );

  // Unmapped addresses end here
  default_slave u_default_slave (
    .clk  (clk),
    .rstn (rstn),
    .aw   (s2_aw),
    .b    (s2_b)
  );

endmodule

/* src/axi_params.svh */
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// Master-side field widths
`define AXI_ID_BITS   4
`define AXI_ADDR_BITS 32
`define AXI_LEN_BITS  8
`define AXI_SIZE_BITS 3

// Routing tag prepended to the ID on the slave side
`define AXI_TAG_BITS  4
`define AXI_IDS_BITS  (`AXI_TAG_BITS + `AXI_ID_BITS)

`endif

/* src/axi_pkg.sv */
package axi_pkg;

  // Burst kind, encoding 2'b11 is reserved
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  // Write response code
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

endpackage

/* src/b_if.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

interface b_if #(
  parameter int ID_BITS = `AXI_ID_BITS
);
  import axi_pkg::*;

  logic [ID_BITS-1:0] id;
  resp_t              resp;
  logic               valid;
  logic               ready;

  modport sender (output id, resp, valid, input ready);
  modport receiver (input id, resp, valid, output ready);

endinterface

/* src/b_router.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

module b_router (
  input logic    clk,
  input logic    rstn,
  b_if.receiver  s0,
  b_if.receiver  s1,
  b_if.receiver  s2,
  b_if.sender    m,
  output logic   b_done
);
  import xbar_pkg::*;

  addr_dec_result_t         src_pick;
  addr_dec_result_t         src_q;
  addr_dec_result_t         src;
  logic                     held;
  logic [`AXI_IDS_BITS-1:0] tagged_id;

  // Fixed priority, slave 0 first
  always_comb begin
    if (s0.valid) begin
      src_pick = SLAVE_0;
    end else if (s1.valid) begin
      src_pick = SLAVE_1;
    end else begin
      src_pick = SLAVE_DEFAULT;
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      held  <= 1'b0;
      src_q <= SLAVE_0;
    end else if (m.valid && m.ready) begin
      held <= 1'b0;
    end else if (m.valid && !held) begin
      held  <= 1'b1;
      src_q <= src_pick;
    end
  end

  assign src = held ? src_q : src_pick;

  always_comb begin
    unique case (src)
      SLAVE_0: begin
        m.valid   = s0.valid;
        m.resp    = s0.resp;
        tagged_id = s0.id;
      end
      SLAVE_1: begin
        m.valid   = s1.valid;
        m.resp    = s1.resp;
        tagged_id = s1.id;
      end
      default: begin
        m.valid   = s2.valid;
        m.resp    = s2.resp;
        tagged_id = s2.id;
      end
    endcase
  end

  // Drop the routing tag
  assign m.id = tagged_id[`AXI_ID_BITS-1:0];

  assign s0.ready = m.ready & (src == SLAVE_0);
  assign s1.ready = m.ready & (src == SLAVE_1);
  assign s2.ready = m.ready & (src == SLAVE_DEFAULT);

  assign b_done = m.valid & m.ready;

endmodule

/* src/default_slave.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

module default_slave (
  input logic    clk,
  input logic    rstn,
  aw_if.receiver aw,
  b_if.sender    b
);
  import axi_pkg::*;

  logic                     busy;
  logic [`AXI_IDS_BITS-1:0] id_q;

  // Busy from the address handshake until the response is taken
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      busy <= 1'b0;
    end else if (aw.valid && aw.ready) begin
      busy <= 1'b1;
    end else if (b.valid && b.ready) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw.valid && aw.ready) begin
      id_q <= aw.id;
    end
  end

  assign aw.ready = ~busy;

  assign b.valid = busy;
  assign b.id    = id_q;
  assign b.resp  = RESP_DECERR;

endmodule

/* src/xbar_pkg.sv */
`include "axi_params.svh"

package xbar_pkg;

  typedef struct packed {
    logic [15:0] region;
    logic [15:0] offset;
  } addr_fields_t;

  // One address word, raw for the slaves, split for the decoder
  typedef union packed {
    logic [`AXI_ADDR_BITS-1:0] raw;
    addr_fields_t              fields;
  } addr_view_u;

  typedef enum logic [1:0] {
    SLAVE_0,
    SLAVE_1,
    SLAVE_DEFAULT
  } addr_dec_result_t;

  typedef enum logic {
    LOCK_FREE,
    LOCK_M1
  } addr_arb_lock_t;

  localparam logic [`AXI_TAG_BITS-1:0] AXI_MASTER_1_ID = `AXI_TAG_BITS'd1;

  // Address map
  function automatic addr_dec_result_t addr_decoder(input addr_view_u addr);
    addr_dec_result_t result;
    case (addr.fields.region)
      16'h0000: result = SLAVE_0;
      16'h0001: result = SLAVE_1;
      default:  result = SLAVE_DEFAULT;
    endcase
    return result;
  endfunction

endpackage

/* test/tb_axi_aw_xbar.sv */
`timescale 1ns/1ps
`include "axi_params.svh"

// Slave that accepts one address and answers OKAY after b_wait cycles
module okay_slave_model (
  input  logic                     clk,
  input  logic                     hold,
  input  int                       b_wait,
  input  logic [`AXI_IDS_BITS-1:0] awid,
  input  logic                     awvalid,
  output logic                     awready,
  output logic [`AXI_IDS_BITS-1:0] bid,
  output axi_pkg::resp_t           bresp,
  output logic                     bvalid,
  input  logic                     bready
);
  import axi_pkg::*;

  logic                     busy;
  logic                     aw_fire;
  logic                     b_fire;
  logic [`AXI_IDS_BITS-1:0] pend_id;
  int                       wait_cnt;

  assign awready = ~busy & ~hold;

  initial begin
    busy = 1'b0;
    bvalid = 1'b0;
    bid = '0;
    bresp = RESP_OKAY;
    pend_id = '0;
    wait_cnt = 0;
    forever begin
      // Handshakes seen where the inputs are settled
      @(negedge clk);
      aw_fire = awvalid & awready;
      b_fire = bvalid & bready;
      if (aw_fire) begin
        pend_id = awid;
      end
      @(posedge clk);
      #1;
      if (b_fire) begin
        bvalid = 1'b0;
        busy = 1'b0;
      end
      if (aw_fire) begin
        busy = 1'b1;
        wait_cnt = b_wait;
      end else if (busy && !bvalid && wait_cnt > 0) begin
        wait_cnt = wait_cnt - 1;
      end
      if (busy && !bvalid && wait_cnt == 0) begin
        bvalid = 1'b1;
        bid = pend_id;
      end
    end
  end

endmodule

module tb_axi_aw_xbar;
  import axi_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  localparam logic [`AXI_TAG_BITS-1:0] MASTER_TAG = 4'd1;
  // Reset plus five directed tests of up to 40 cycles and twenty random writes of up to 25
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 * 40 + 20 * 25;

  logic                      clk;
  logic                      rstn;
  logic [`AXI_ID_BITS-1:0]   awid;
  logic [`AXI_ADDR_BITS-1:0] awaddr;
  logic [`AXI_LEN_BITS-1:0]  awlen;
  logic [`AXI_SIZE_BITS-1:0] awsize;
  burst_t                    awburst;
  logic                      awvalid;
  logic                      awready;
  logic [`AXI_ID_BITS-1:0]   bid;
  resp_t                     bresp;
  logic                      bvalid;
  logic                      bready;
  logic [`AXI_IDS_BITS-1:0]  s0_awid;
  logic [`AXI_ADDR_BITS-1:0] s0_awaddr;
  logic [`AXI_LEN_BITS-1:0]  s0_awlen;
  logic [`AXI_SIZE_BITS-1:0] s0_awsize;
  burst_t                    s0_awburst;
  logic                      s0_awvalid;
  logic                      s0_awready;
  logic [`AXI_IDS_BITS-1:0]  s0_bid;
  resp_t                     s0_bresp;
  logic                      s0_bvalid;
  logic                      s0_bready;
  logic [`AXI_IDS_BITS-1:0]  s1_awid;
  logic [`AXI_ADDR_BITS-1:0] s1_awaddr;
  logic [`AXI_LEN_BITS-1:0]  s1_awlen;
  logic [`AXI_SIZE_BITS-1:0] s1_awsize;
  burst_t                    s1_awburst;
  logic                      s1_awvalid;
  logic                      s1_awready;
  logic [`AXI_IDS_BITS-1:0]  s1_bid;
  resp_t                     s1_bresp;
  logic                      s1_bvalid;
  logic                      s1_bready;
  logic                      s0_hold;
  logic                      s1_hold;
  int                        s0_b_wait;
  int                        s1_b_wait;
  int                        seed;
  int                        cycle_count = 0;

  axi_aw_xbar uut (
    .clk        (clk),
    .rstn       (rstn),
    .awid       (awid),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .awsize     (awsize),
    .awburst    (awburst),
    .awvalid    (awvalid),
    .awready    (awready),
    .bid        (bid),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .s0_awid    (s0_awid),
    .s0_awaddr  (s0_awaddr),
    .s0_awlen   (s0_awlen),
    .s0_awsize  (s0_awsize),
    .s0_awburst (s0_awburst),
    .s0_awvalid (s0_awvalid),
    .s0_awready (s0_awready),
    .s0_bid     (s0_bid),
    .s0_bresp   (s0_bresp),
    .s0_bvalid  (s0_bvalid),
    .s0_bready  (s0_bready),
    .s1_awid    (s1_awid),
    .s1_awaddr  (s1_awaddr),
    .s1_awlen   (s1_awlen),
    .s1_awsize  (s1_awsize),
    .s1_awburst (s1_awburst),
    .s1_awvalid (s1_awvalid),
    .s1_awready (s1_awready),
    .s1_bid     (s1_bid),
    .s1_bresp   (s1_bresp),
    .s1_bvalid  (s1_bvalid),
    .s1_bready  (s1_bready)
  );

  okay_slave_model s0_model (
    .clk     (clk),
    .hold    (s0_hold),
    .b_wait  (s0_b_wait),
    .awid    (s0_awid),
    .awvalid (s0_awvalid),
    .awready (s0_awready),
    .bid     (s0_bid),
    .bresp   (s0_bresp),
    .bvalid  (s0_bvalid),
    .bready  (s0_bready)
  );

  okay_slave_model s1_model (
    .clk     (clk),
    .hold    (s1_hold),
    .b_wait  (s1_b_wait),
    .awid    (s1_awid),
    .awvalid (s1_awvalid),
    .awready (s1_awready),
    .bid     (s1_bid),
    .bresp   (s1_bresp),
    .bvalid  (s1_bvalid),
    .bready  (s1_bready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, a handshake never completed", cycle_count);
      stop_with_failure();
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  // Region 0 to slave 0, region 1 to slave 1, any other region to the default slave
  function automatic int expected_target(input logic [31:0] addr);
    if (addr[31:16] == 16'h0000) begin
      return 0;
    end else if (addr[31:16] == 16'h0001) begin
      return 1;
    end else begin
      return 2;
    end
  endfunction

  task automatic set_aw(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                        input logic [2:0] size, input burst_t burst);
    awid = id;
    awaddr = addr;
    awlen = len;
    awsize = size;
    awburst = burst;
    awvalid = 1'b1;
  endtask

  task automatic drive_aw(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len,
                          input logic [2:0] size, input burst_t burst);
    @(posedge clk);
    #1;
    set_aw(id, addr, len, size, burst);
  endtask

  task automatic check_payload(input string port, input logic [7:0] id, input logic [31:0] addr,
                               input logic [7:0] len, input logic [2:0] size,
                               input logic [1:0] burst);
    check_value({port, "_awid"}, id, {MASTER_TAG, awid});
    check_value({port, "_awaddr"}, addr, awaddr);
    check_value({port, "_awlen"}, len, awlen);
    check_value({port, "_awsize"}, size, awsize);
    check_value({port, "_awburst"}, burst, awburst);
  endtask

  task automatic check_routing(input int target);
    check_value("s0_awvalid", s0_awvalid, target == 0);
    check_value("s1_awvalid", s1_awvalid, target == 1);
    if (target == 0) begin
      check_payload("s0", s0_awid, s0_awaddr, s0_awlen, s0_awsize, s0_awburst);
    end else if (target == 1) begin
      check_payload("s1", s1_awid, s1_awaddr, s1_awlen, s1_awsize, s1_awburst);
    end
  endtask

  task automatic wait_aw_accept(input int target);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      check_routing(target);
      accepted = awready;
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
  endtask

  // Response on the master side, with bready returned only to its source
  task automatic check_response(input logic [3:0] id, input resp_t resp, input int target);
    check_value("bid", bid, id);
    check_value("bresp", bresp, resp);
    check_value("s0_bready", s0_bready, bready && (target == 0));
    check_value("s1_bready", s1_bready, bready && (target == 1));
    @(posedge clk);
    #1;
  endtask

  // Expects bready high
  task automatic wait_response(input logic [3:0] id, input resp_t resp, input int target);
    do begin
      @(negedge clk);
    end while (!bvalid);
    check_response(id, resp, target);
  endtask

  task automatic test_slave0_write();
    drive_aw(4'h5, 32'h0000_1234, 8'd3, 3'd2, BURST_INCR);
    wait_aw_accept(0);
    wait_response(4'h5, RESP_OKAY, 0);
  endtask

  task automatic test_slave1_write();
    drive_aw(4'hA, 32'h0001_ABC0, 8'd15, 3'd3, BURST_WRAP);
    wait_aw_accept(1);
    wait_response(4'hA, RESP_OKAY, 1);
  endtask

  task automatic test_unmapped_write();
    drive_aw(4'h9, 32'h00F0_0010, 8'd0, 3'd1, BURST_FIXED);
    wait_aw_accept(2);
    wait_response(4'h9, RESP_DECERR, 2);
  endtask

  task automatic test_blocked_second_write();
    s0_b_wait = 6;
    drive_aw(4'h3, 32'h0000_0040, 8'd1, 3'd2, BURST_INCR);
    wait_aw_accept(0);
    set_aw(4'h7, 32'h0001_0080, 8'd7, 3'd2, BURST_INCR);
    // Second address waits for the first response
    do begin
      @(negedge clk);
      check_value("awready", awready, 1'b0);
      check_value("s1_awvalid", s1_awvalid, 1'b0);
    end while (!bvalid);
    check_response(4'h3, RESP_OKAY, 0);
    wait_aw_accept(1);
    wait_response(4'h7, RESP_OKAY, 1);
    s0_b_wait = 1;
  endtask

  task automatic test_back_pressure();
    s0_hold = 1'b1;
    bready = 1'b0;
    drive_aw(4'hC, 32'h0000_8000, 8'd31, 3'd2, BURST_INCR);
    repeat (4) begin
      @(negedge clk);
      check_value("awready", awready, 1'b0);
      check_routing(0);
    end
    @(posedge clk);
    #1;
    s0_hold = 1'b0;
    wait_aw_accept(0);
    do begin
      @(negedge clk);
    end while (!bvalid);
    repeat (3) begin
      @(negedge clk);
      check_value("bvalid", bvalid, 1'b1);
      check_value("bid", bid, 4'hC);
      check_value("bresp", bresp, RESP_OKAY);
      check_value("s0_bready", s0_bready, 1'b0);
      check_value("awready", awready, 1'b0);
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    wait_response(4'hC, RESP_OKAY, 0);
  endtask

  task automatic test_random_writes();
    logic [31:0] addr;
    logic [3:0]  id;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst_bits;
    int          kind;
    int          target;
    for (int i = 0; i < 20; i++) begin
      addr = $random(seed);
      kind = {$random(seed)} % 4;
      // Half of the writes go to the mapped regions
      if (kind == 0) begin
        addr[31:16] = 16'h0000;
      end else if (kind == 1) begin
        addr[31:16] = 16'h0001;
      end
      id = $random(seed);
      len = $random(seed);
      size = $random(seed);
      burst_bits = {$random(seed)} % 3;
      s0_b_wait = {$random(seed)} % 4;
      s1_b_wait = {$random(seed)} % 4;
      target = expected_target(addr);
      drive_aw(id, addr, len, size, burst_t'(burst_bits));
      wait_aw_accept(target);
      wait_response(id, (target == 2) ? RESP_DECERR : RESP_OKAY, target);
    end
  endtask

  initial begin
    seed = 60;
    rstn = 1'b0;
    awid = '0;
    awaddr = '0;
    awlen = '0;
    awsize = '0;
    awburst = BURST_FIXED;
    awvalid = 1'b0;
    bready = 1'b1;
    s0_hold = 1'b0;
    s1_hold = 1'b0;
    s0_b_wait = 1;
    s1_b_wait = 2;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    check_value("s0_awvalid", s0_awvalid, 1'b0);
    check_value("s1_awvalid", s1_awvalid, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    test_slave0_write();
    test_slave1_write();
    test_unmapped_write();
    test_blocked_second_write();
    test_back_pressure();
    test_random_writes();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
